//--- dv/cryGolden.txt
# W chan addr data | P name fmt word rgb | X chan addr data name fmt word rgb | I
# chan is R, G or B; fmt is cry or rgb16; addr, data, word and rgb in hex
W R 2D 2B
W G 2D 91
W B 2D FF
W R 88 C8
W G 88 C8
W B 88 C8
W R F0 10
W G F0 A4
W B F0 E0
W R 0F FF
W G 0F 40
I
# Full intensity returns the loaded levels
P full2D cry 2DFF 2B91FF
P full88 cry 88FF C8C8C8
P fullF0 cry F0FF 10A4E0
P full0F cry 0FFF FF4000
# Intensity scaling, rounded product over 255
P zero2D cry 2D00 000000
P zeroF0 cry F000 000000
P half2D cry 2D80 164980
P half88 cry 8880 646464
P halfF0 cry F080 085270
P quart2D cry 2D40 0B2440
P quart88 cry 8840 323232
P quart0F cry 0F40 401000
I
# RGB16 pass-through
P rgbWhite rgb16 FFFF FFFFFF
P rgbBlack rgb16 0000 000000
P rgbRed rgb16 F800 FF0000
P rgbBlue rgb16 07C0 0000FF
P rgbGreen rgb16 003F 00FF00
P rgbMid rgb16 8421 848684
P rgbLikeCry rgb16 2D80 2900B5
I
P mixCry0 cry 2DFF 2B91FF
P mixRgb0 rgb16 F800 FF0000
P mixCry1 cry 8880 646464
P mixRgb1 rgb16 003F 00FF00
P mixCry2 cry F040 042938
I
# Channel separation and unloaded entries
W G 2D 33
P sep2D cry 2DFF 2B33FF
P unload55 cry 55FF 000000
I
P burst0 cry 88FF C8C8C8
P burst1 cry 8880 646464
P burst2 cry 8840 323232
P burst3 cry 8800 000000
P burst4 rgb16 FFFF FFFFFF
P burst5 cry F0FF 10A4E0
P burst6 cry F080 085270
P burst7 cry 0FFF FF4000
P burst8 rgb16 8421 848684
P burst9 cry 5580 000000
I
# Write and read of one address in one cycle
X R 88 50 wrSame88 cry 88FF C8C8C8
P wrAfter88 cry 88FF 50C8C8
X B F0 11 wrSameF0 cry F080 085270
P wrAfterF0 cry F080 085209
I

//--- tb.f
src/cryPkg.sv
src/tableBusPkg.sv
src/cryColorRom.sv
src/cryIntensityScale.sv
src/cryPixelTracker.sv
src/cryToRgb.sv
dv/cryToRgbTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CRY to RGB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f tb.f \
	--top-module cryToRgbTb \
	-Mdir obj_dir \
	-o cryToRgbSim

output="$(./obj_dir/cryToRgbSim)"
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
	exit 0
else
	exit 1
fi

//--- dv/cryToRgbTb.sv
module cryToRgbTb;

	timeunit 1ns;
	timeprecision 100ps;

	import cryPkg::*;
	import tableBusPkg::*;

	localparam int ResetCycles = 16;
	localparam int Latency     = 3;  // Table read, scale, output register
	localparam int DrainCycles = 4;  // Idle tail to catch stray results

	typedef enum logic [1:0] {
		recIdle,
		recWrite,
		recPixel,
		recBoth
	} recKindT;

	logic       sys_clk = 1'b0;
	logic       rstN;
	logic       pixelValid;
	pixelInT    pixelIn;
	logic       tabWrValid;
	tableWriteT tabWr;
	logic       rgbValid;
	rgbT        rgbOut;

	// Golden records in file order
	recKindT    recKind [$];
	tableWriteT recWr   [$];
	pixelInT    recPix  [$];
	string      recName [$];
	rgbT        recExp  [$];

	// Results still owed by the DUT, indexed by readIdx
	string expName  [$];
	rgbT   expRgb   [$];
	int    expCycle [$];
	int    readIdx    = 0;

	int cycleCount = 0;
	int cycleLimit = 0;
	int checkCount = 0;
	int loadErrors = 0;
	int runErrors  = 0;

	cryToRgb i_cryToRgb (
		.sys_clk    (sys_clk),
		.rstN       (rstN),
		.pixelValid (pixelValid),
		.pixelIn    (pixelIn),
		.tabWrValid (tabWrValid),
		.tabWr      (tabWr),
		.rgbValid   (rgbValid),
		.rgbOut     (rgbOut)
	);

	always #10 sys_clk = ~sys_clk; // 20 ns period

	always @(posedge sys_clk) begin
		cycleCount <= cycleCount + 1;
	end

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("Error %s: expected %0h, actual %0h", testName, expected, actual);
			runErrors++;
		end
	endtask

	task automatic finishRun();
		if (checkCount == 0) begin
			$display("No DUT result was checked");
		end
		$display("Checks %0d, load errors %0d, run errors %0d",
			checkCount, loadErrors, runErrors);
		if (loadErrors == 0 && runErrors == 0 && checkCount != 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	function automatic channelT parseChannel(input string text);
		if (text == "R") return chanRed;
		if (text == "G") return chanGreen;
		if (text == "B") return chanBlue;
		$display("Golden file names an unknown channel %s", text);
		loadErrors++;
		return chanRed;
	endfunction

	function automatic pixFmtT parseFormat(input string text);
		if (text == "cry") return fmtCry;
		if (text == "rgb16") return fmtRgb16;
		$display("Golden file names an unknown pixel format %s", text);
		loadErrors++;
		return fmtCry;
	endfunction

	task automatic addRecord(input recKindT kind, input tableWriteT wr, input pixelInT pix,
			input string name, input rgbT exp);
		recKind.push_back(kind);
		recWr.push_back(wr);
		recPix.push_back(pix);
		recName.push_back(name);
		recExp.push_back(exp);
	endtask

	task automatic loadGolden();
		int          fd;
		int          n;
		string       tag;
		string       line;
		string       chanText;
		string       fmtText;
		string       name;
		logic [7:0]  addr;
		logic [7:0]  data;
		logic [15:0] word;
		logic [23:0] rgb;
		tableWriteT  wr;
		pixelInT     pix;
		fd = $fopen("dv/cryGolden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file dv/cryGolden.txt");
			loadErrors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tag);
			if (n != 1) break;
			wr   = '0;
			pix  = '0;
			name = "";
			rgb  = '0;
			if (tag == "#") begin
				n = $fgets(line, fd); // Comment line
			end else if (tag == "I") begin
				addRecord(recIdle, wr, pix, name, rgb);
			end else if (tag == "W") begin
				n = $fscanf(fd, "%s %h %h", chanText, addr, data);
				if (n != 3) begin
					$display("Golden file has a short W record");
					loadErrors++;
				end
				wr.channel = parseChannel(chanText);
				wr.addr    = addr;
				wr.data    = data;
				addRecord(recWrite, wr, pix, name, rgb);
			end else if (tag == "P") begin
				n = $fscanf(fd, "%s %s %h %h", name, fmtText, word, rgb);
				if (n != 4) begin
					$display("Golden file has a short P record");
					loadErrors++;
				end
				pix.fmt  = parseFormat(fmtText);
				pix.word = word;
				addRecord(recPixel, wr, pix, name, rgb);
			end else if (tag == "X") begin
				n = $fscanf(fd, "%s %h %h %s %s %h %h",
					chanText, addr, data, name, fmtText, word, rgb);
				if (n != 7) begin
					$display("Golden file has a short X record");
					loadErrors++;
				end
				wr.channel = parseChannel(chanText);
				wr.addr    = addr;
				wr.data    = data;
				pix.fmt    = parseFormat(fmtText);
				pix.word   = word;
				addRecord(recBoth, wr, pix, name, rgb);
			end else begin
				$display("Golden file has an unknown record type %s", tag);
				loadErrors++;
				n = $fgets(line, fd);
			end
		end
		$fclose(fd);
	endtask

	// Puts one record on the DUT inputs and books its result
	task automatic driveRecord(input int idx);
		pixelValid = 1'b0;
		tabWrValid = 1'b0;
		if (recKind[idx] == recWrite || recKind[idx] == recBoth) begin
			tabWr      = recWr[idx];
			tabWrValid = 1'b1;
		end
		if (recKind[idx] == recPixel || recKind[idx] == recBoth) begin
			pixelIn    = recPix[idx];
			pixelValid = 1'b1;
			expName.push_back(recName[idx]);
			expRgb.push_back(recExp[idx]);
			expCycle.push_back(cycleCount);
		end
	endtask

	initial begin : driveStimulus
		rstN       = 1'b0;
		pixelValid = 1'b0;
		pixelIn    = '0;
		tabWrValid = 1'b0;
		tabWr      = '0;
		loadGolden();
		cycleLimit = ResetCycles + (recKind.size() + Latency) * 2;
		repeat (ResetCycles) @(posedge sys_clk);
		#1;
		rstN = 1'b1;
		foreach (recKind[i]) begin
			driveRecord(i);
			@(posedge sys_clk);
			#1; // Inputs move just after the edge
		end
		pixelValid = 1'b0;
		tabWrValid = 1'b0;
		while (readIdx < expRgb.size()) @(posedge sys_clk);
		repeat (DrainCycles) @(posedge sys_clk);
		finishRun();
	end

	// Outputs are stable mid-cycle
	always @(negedge sys_clk) begin : checkOutputs
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			runErrors++;
			finishRun();
		end else if (rstN && rgbValid) begin
			if (readIdx >= expRgb.size()) begin
				$display("DUT gave result %0h with no pixel waiting for one", rgbOut);
				runErrors++;
			end else begin
				checkValue(expName[readIdx], {8'h00, expRgb[readIdx]}, {8'h00, rgbOut});
				checkValue({expName[readIdx], " latency"}, Latency,
					cycleCount - expCycle[readIdx]);
				readIdx++;
			end
		end
	end

endmodule

//--- src/cryToRgb.sv
module cryToRgb (
	input  logic                    sys_clk,
	input  logic                    rstN,
	input  logic                    pixelValid,
	input  tableBusPkg::pixelInT    pixelIn,
	input  logic                    tabWrValid,
	input  tableBusPkg::tableWriteT tabWr,
	output logic                    rgbValid,
	output cryPkg::rgbT             rgbOut
);

	import cryPkg::*;

	cryPixelT   pixelCry;
	logic [7:0] levelRed;
	logic [7:0] levelGreen;
	logic [7:0] levelBlue;
	logic [7:0] scaledRed;
	logic [7:0] scaledGreen;
	logic [7:0] scaledBlue;
	logic [7:0] stageIntensity;
	rgbT        scaledRgb;

	// Tables look up every cycle, the tracker drops RGB16 results later
	assign pixelCry = cryPixelT'(pixelIn.word);

	cryColorRom #(.ChannelId(chanRed)) i_redRom (
		.sys_clk    (sys_clk),
		.rstN       (rstN),
		.tabWrValid (tabWrValid),
		.tabWr      (tabWr),
		.addr       (pixelCry.color),
		.level      (levelRed)
	);

	cryColorRom #(.ChannelId(chanGreen)) i_greenRom (
		.sys_clk    (sys_clk),
		.rstN       (rstN),
		.tabWrValid (tabWrValid),
		.tabWr      (tabWr),
		.addr       (pixelCry.color),
		.level      (levelGreen)
	);

	cryColorRom #(.ChannelId(chanBlue)) i_blueRom (
		.sys_clk    (sys_clk),
		.rstN       (rstN),
		.tabWrValid (tabWrValid),
		.tabWr      (tabWr),
		.addr       (pixelCry.color),
		.level      (levelBlue)
	);

	// Intensity arrives one cycle late, in step with the levels
	cryIntensityScale i_redScale (
		.sys_clk   (sys_clk),
		.level     (levelRed),
		.intensity (stageIntensity),
		.scaled    (scaledRed)
	);

	cryIntensityScale i_greenScale (
		.sys_clk   (sys_clk),
		.level     (levelGreen),
		.intensity (stageIntensity),
		.scaled    (scaledGreen)
	);

	cryIntensityScale i_blueScale (
		.sys_clk   (sys_clk),
		.level     (levelBlue),
		.intensity (stageIntensity),
		.scaled    (scaledBlue)
	);

	assign scaledRgb = '{red: scaledRed, green: scaledGreen, blue: scaledBlue};

	cryPixelTracker i_tracker (
		.sys_clk        (sys_clk),
		.rstN           (rstN),
		.pixelValid     (pixelValid),
		.pixelIn        (pixelIn),
		.stageIntensity (stageIntensity),
		.scaledRgb      (scaledRgb),
		.rgbValid       (rgbValid),
		.rgbOut         (rgbOut)
	);

endmodule

//--- src/cryPixelTracker.sv
module cryPixelTracker (
	input  logic                sys_clk,
	input  logic                rstN,
	input  logic                pixelValid,
	input  tableBusPkg::pixelInT pixelIn,
	output logic [7:0]          stageIntensity,
	input  cryPkg::rgbT         scaledRgb,
	output logic                rgbValid,
	output cryPkg::rgbT         rgbOut
);

	import cryPkg::*;
	import tableBusPkg::*;

	logic     validRead;  // Pixel whose table read is in progress
	logic     validScale; // Pixel in the scaler stage
	pixelInT  pixRead;
	pixelInT  pixScale;
	cryPixelT cryRead;
	rgb16T    rgb16Word;
	rgbT      rgb16Wide;
	rgbT      nextRgb;

	// Valid pipe, three deep counting the output register
	always_ff @(posedge sys_clk) begin
		if (!rstN) begin
			validRead  <= 1'b0;
			validScale <= 1'b0;
			rgbValid   <= 1'b0;
		end else begin
			validRead  <= pixelValid;
			validScale <= validRead;
			rgbValid   <= validScale;
		end
	end

	// Side information follows the valid bits
	always_ff @(posedge sys_clk) begin
		pixRead  <= pixelIn;
		pixScale <= pixRead;
	end

	// Levels leave the tables now, so hand the matching intensity over
	assign cryRead        = cryPixelT'(pixRead.word);
	assign stageIntensity = cryRead.intensity;

	// RGB16 expansion, top bits repeated into the low bits
	assign rgb16Word       = rgb16T'(pixScale.word);
	assign rgb16Wide.red   = {rgb16Word.red, rgb16Word.red[4:2]};
	assign rgb16Wide.green = {rgb16Word.green, rgb16Word.green[5:4]};
	assign rgb16Wide.blue  = {rgb16Word.blue, rgb16Word.blue[4:2]};

	always_comb begin
		unique case (pixScale.fmt)
			fmtRgb16: nextRgb = rgb16Wide; // Tables bypassed
			default:  nextRgb = scaledRgb;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		rgbOut <= nextRgb;
	end

endmodule

//--- src/cryIntensityScale.sv
module cryIntensityScale (
	input  logic       sys_clk,
	input  logic [7:0] level,
	input  logic [7:0] intensity,
	output logic [7:0] scaled
);

	// round(level * intensity / 255) without a divider
	// x/255 is close to (x + x/256) / 256 and the half-LSB bias
	// makes it exact over the full 8x8 product range
	logic [15:0] product;
	logic [15:0] biased;
	logic [15:0] corrected;

	assign product = {8'h00, level} * {8'h00, intensity}; // At most 65025
	assign biased  = product + 16'd128;     // Round to nearest
	assign corrected = biased + {8'h00, biased[15:8]}; // Peaks at 65407 so no carry out

	always_ff @(posedge sys_clk) begin
		scaled <= corrected[15:8];
	end

endmodule

//--- src/cryColorRom.sv
module cryColorRom #(
	parameter cryPkg::channelT ChannelId = cryPkg::chanRed
) (
	input  logic                   sys_clk,
	input  logic                   rstN,
	input  logic                   tabWrValid,
	input  tableBusPkg::tableWriteT tabWr,
	input  logic [7:0]             addr,
	output logic [7:0]             level
);

	// 256 levels indexed by the colour byte, all zero at power up
	logic [7:0] colorTable [256] = '{default: 8'h00};
	logic       wrHit;

	// Only writes tagged with our own channel land here
	// Writes are ignored while the block is held in reset
	assign wrHit = rstN && tabWrValid && (tabWr.channel == ChannelId);

	always_ff @(posedge sys_clk) begin
		if (wrHit) begin
			colorTable[tabWr.addr] <= tabWr.data;
		end
	end

	// Registered read, same-cycle write to this address shows next cycle
	always_ff @(posedge sys_clk) begin
		level <= colorTable[addr];
	end

endmodule

//--- src/tableBusPkg.sv
package tableBusPkg;

	// One write into a colour table
	typedef struct packed {
		cryPkg::channelT channel; // Which table takes it
		logic [7:0]      addr;    // Colour byte
		logic [7:0]      data;    // Full-intensity level
	} tableWriteT;

	// One pixel on the input strobe
	typedef struct packed {
		cryPkg::pixFmtT fmt;
		logic [15:0]    word; // cryPixelT when fmt is fmtCry
	} pixelInT;

endpackage

//--- src/cryPkg.sv
package cryPkg;

	// Selects one of the three colour tables
	typedef enum logic [1:0] {
		chanRed   = 2'd0,
		chanGreen = 2'd1,
		chanBlue  = 2'd2
	} channelT;

	// How a pixel word is interpreted
	typedef enum logic {
		fmtCry   = 1'b0,
		fmtRgb16 = 1'b1
	} pixFmtT;

	// CRY word: colour byte is cyan nibble over red nibble
	typedef struct packed {
		logic [7:0] color;
		logic [7:0] intensity;
	} cryPixelT;

	// Direct RGB16 word, note blue sits between red and green
	typedef struct packed {
		logic [4:0] red;
		logic [4:0] blue;
		logic [5:0] green;
	} rgb16T;

	// 24-bit output triple
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

endpackage
